// ==== rtl/ex_data_pkg.sv ====
package ex_data_pkg;

    // general purpose register word
    localparam int WORD_W = 32;

    // HI/LO pair, also the full product width
    localparam int DWORD_W = 64;

    // destination register index
    localparam int REG_ADDR_W = 5;

    // shift amount, low bits of operand 1
    localparam int SHAMT_W = 5;

    // leading zero/one count, 0..32
    localparam int CNT_W = 6;

endpackage

// ==== rtl/ex_isa_pkg.sv ====
package ex_isa_pkg;

    typedef enum logic [7:0] {
        OP_NOP   = 8'b0000_0000,
        OP_AND   = 8'b0010_0100,
        OP_OR    = 8'b0010_0101,
        OP_XOR   = 8'b0010_0110,
        OP_NOR   = 8'b0010_0111,
        OP_SLL   = 8'b0111_1100,
        OP_SRL   = 8'b0000_0010,
        OP_SRA   = 8'b0000_0011,
        OP_ADD   = 8'b0010_0000,
        OP_ADDU  = 8'b0010_0001,
        OP_ADDI  = 8'b0101_0101,
        OP_ADDIU = 8'b0101_0110,
        OP_SUB   = 8'b0010_0010,
        OP_SUBU  = 8'b0010_0011,
        OP_SLT   = 8'b0010_1010,
        OP_SLTU  = 8'b0010_1011,
        OP_CLZ   = 8'b1011_0000,
        OP_CLO   = 8'b1011_0001,
        OP_TEQ   = 8'b0011_0100,
        OP_TNE   = 8'b0011_0110,
        OP_TGE   = 8'b0011_0000,
        OP_TGEU  = 8'b0011_0001,
        OP_TLT   = 8'b0011_0010,
        OP_TLTU  = 8'b0011_0011,
        OP_MUL   = 8'b1010_1001,
        OP_MULT  = 8'b0001_1000,
        OP_MULTU = 8'b0001_1001,
        OP_MADD  = 8'b1010_0110,
        OP_MADDU = 8'b1010_1000,
        OP_MSUB  = 8'b1010_1010,
        OP_MSUBU = 8'b1010_1011,
        OP_MFHI  = 8'b0001_0000,
        OP_MTHI  = 8'b0001_0001,
        OP_MFLO  = 8'b0001_0010,
        OP_MTLO  = 8'b0001_0011
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NONE  = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100,
        SEL_MUL   = 3'b101
    } alusel_e;

    // result group of each opcode, no register result means SEL_NONE
    function automatic alusel_e alusel_of(aluop_e op);
        case (op)
            OP_AND, OP_OR, OP_XOR, OP_NOR: return SEL_LOGIC;
            OP_SLL, OP_SRL, OP_SRA: return SEL_SHIFT;
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU,
            OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
            OP_CLZ, OP_CLO: return SEL_ARITH;
            OP_MFHI, OP_MFLO: return SEL_MOVE;
            OP_MUL: return SEL_MUL;
            default: return SEL_NONE;
        endcase
    endfunction

endpackage

// ==== rtl/ex_logic_shift.sv ====
`timescale 1ns/1ns

module ex_logic_shift (
    input  ex_isa_pkg::aluop_e              aluop_i,
    input  logic [ex_data_pkg::WORD_W-1:0]  reg1_i,
    input  logic [ex_data_pkg::WORD_W-1:0]  reg2_i,
    output logic [ex_data_pkg::WORD_W-1:0]  result_o
);

    logic [ex_data_pkg::SHAMT_W-1:0] shamt;

    // only the low bits count, so shifts wrap modulo 32
    assign shamt = reg1_i[ex_data_pkg::SHAMT_W-1:0];

    always_comb begin
        case (aluop_i)
            ex_isa_pkg::OP_AND: begin
                result_o = reg1_i & reg2_i;
            end
            ex_isa_pkg::OP_OR: begin
                result_o = reg1_i | reg2_i;
            end
            ex_isa_pkg::OP_XOR: begin
                result_o = reg1_i ^ reg2_i;
            end
            ex_isa_pkg::OP_NOR: begin
                result_o = ~(reg1_i | reg2_i);
            end
            ex_isa_pkg::OP_SLL: begin
                result_o = reg2_i << shamt;
            end
            ex_isa_pkg::OP_SRL: begin
                result_o = reg2_i >> shamt;
            end
            ex_isa_pkg::OP_SRA: begin
                // sign fill from operand 2
                result_o = $signed(reg2_i) >>> shamt;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== rtl/ex_alu_arith.sv ====
`timescale 1ns/1ns

module ex_alu_arith (
    input  ex_isa_pkg::aluop_e              aluop_i,
    input  logic [ex_data_pkg::WORD_W-1:0]  reg1_i,
    input  logic [ex_data_pkg::WORD_W-1:0]  reg2_i,
    output logic [ex_data_pkg::WORD_W-1:0]  result_o,
    output logic                            ov_o,
    output logic                            trap_o
);

    logic                           sub_op;
    logic [ex_data_pkg::WORD_W-1:0] add_b;
    logic [ex_data_pkg::WORD_W-1:0] sum;
    logic                           overflow;
    logic                           lt_signed;
    logic                           lt_unsigned;
    logic [ex_data_pkg::WORD_W-1:0] clz_src;
    logic [ex_data_pkg::CNT_W-1:0]  lead_cnt;
    logic                           found;

    // signed compares go through the subtractor
    assign sub_op = aluop_i inside {ex_isa_pkg::OP_SUB, ex_isa_pkg::OP_SUBU,
                                    ex_isa_pkg::OP_SLT, ex_isa_pkg::OP_TGE,
                                    ex_isa_pkg::OP_TLT};

    // two's complement as inverted operand plus carry in
    assign add_b = sub_op ? ~reg2_i : reg2_i;
    assign sum   = reg1_i + add_b + {{(ex_data_pkg::WORD_W-1){1'b0}}, sub_op};

    assign overflow = (reg1_i[ex_data_pkg::WORD_W-1] == add_b[ex_data_pkg::WORD_W-1])
                   && (sum[ex_data_pkg::WORD_W-1] != reg1_i[ex_data_pkg::WORD_W-1]);

    assign lt_signed   = overflow ? !sum[ex_data_pkg::WORD_W-1] : sum[ex_data_pkg::WORD_W-1];
    assign lt_unsigned = reg1_i < reg2_i;

    // only the trapping adds report overflow
    assign ov_o = overflow && (aluop_i inside {ex_isa_pkg::OP_ADD, ex_isa_pkg::OP_ADDI,
                                               ex_isa_pkg::OP_SUB});

    // CLO counts zeros of the inverted word
    assign clz_src = (aluop_i == ex_isa_pkg::OP_CLO) ? ~reg1_i : reg1_i;

    always_comb begin
        lead_cnt = '0;
        found    = 1'b0;
        for (int i = ex_data_pkg::WORD_W - 1; i >= 0; i--) begin
            if (clz_src[i]) begin
                found = 1'b1;
            end else if (!found) begin
                lead_cnt = lead_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        case (aluop_i)
            ex_isa_pkg::OP_ADD, ex_isa_pkg::OP_ADDU, ex_isa_pkg::OP_ADDI,
            ex_isa_pkg::OP_ADDIU, ex_isa_pkg::OP_SUB, ex_isa_pkg::OP_SUBU: begin
                result_o = sum;
            end
            ex_isa_pkg::OP_SLT: begin
                result_o = {{(ex_data_pkg::WORD_W-1){1'b0}}, lt_signed};
            end
            ex_isa_pkg::OP_SLTU: begin
                result_o = {{(ex_data_pkg::WORD_W-1){1'b0}}, lt_unsigned};
            end
            ex_isa_pkg::OP_CLZ, ex_isa_pkg::OP_CLO: begin
                result_o = {{(ex_data_pkg::WORD_W-ex_data_pkg::CNT_W){1'b0}}, lead_cnt};
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

    always_comb begin
        case (aluop_i)
            ex_isa_pkg::OP_TEQ:  trap_o = (reg1_i == reg2_i);
            ex_isa_pkg::OP_TNE:  trap_o = (reg1_i != reg2_i);
            ex_isa_pkg::OP_TGE:  trap_o = !lt_signed;
            ex_isa_pkg::OP_TLT:  trap_o = lt_signed;
            ex_isa_pkg::OP_TGEU: trap_o = !lt_unsigned;
            ex_isa_pkg::OP_TLTU: trap_o = lt_unsigned;
            default:             trap_o = 1'b0;
        endcase
    end

endmodule

// ==== rtl/ex_mul_acc.sv ====
`timescale 1ns/1ns

module ex_mul_acc (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            start_i,
    input  ex_isa_pkg::aluop_e              aluop_i,
    input  logic [ex_data_pkg::WORD_W-1:0]  reg1_i,
    input  logic [ex_data_pkg::WORD_W-1:0]  reg2_i,
    input  logic [ex_data_pkg::WORD_W-1:0]  hi_i,
    input  logic [ex_data_pkg::WORD_W-1:0]  lo_i,
    output logic [ex_data_pkg::WORD_W-1:0]  mul_lo_o,
    output logic                            hilo_we_o,
    output logic [ex_data_pkg::DWORD_W-1:0] hilo_wdata_o,
    output logic                            acc_busy_o
);

    logic                            signed_op;
    logic                            acc_op;
    logic                            neg_op;
    logic                            mult_op;
    logic [ex_data_pkg::WORD_W-1:0]  mag1;
    logic [ex_data_pkg::WORD_W-1:0]  mag2;
    logic [ex_data_pkg::DWORD_W-1:0] prod_mag;
    logic [ex_data_pkg::DWORD_W-1:0] product;
    logic [ex_data_pkg::DWORD_W-1:0] acc_term;
    logic                            acc_busy;

    assign signed_op = aluop_i inside {ex_isa_pkg::OP_MUL, ex_isa_pkg::OP_MULT,
                                       ex_isa_pkg::OP_MADD, ex_isa_pkg::OP_MSUB};
    assign acc_op    = aluop_i inside {ex_isa_pkg::OP_MADD, ex_isa_pkg::OP_MADDU,
                                       ex_isa_pkg::OP_MSUB, ex_isa_pkg::OP_MSUBU};
    assign neg_op    = aluop_i inside {ex_isa_pkg::OP_MSUB, ex_isa_pkg::OP_MSUBU};
    assign mult_op   = aluop_i inside {ex_isa_pkg::OP_MULT, ex_isa_pkg::OP_MULTU};

    // multiply magnitudes, fix the sign afterwards
    assign mag1 = (signed_op && reg1_i[ex_data_pkg::WORD_W-1]) ? -reg1_i : reg1_i;
    assign mag2 = (signed_op && reg2_i[ex_data_pkg::WORD_W-1]) ? -reg2_i : reg2_i;

    assign prod_mag = {{ex_data_pkg::WORD_W{1'b0}}, mag1}
                    * {{ex_data_pkg::WORD_W{1'b0}}, mag2};

    assign product = (signed_op && (reg1_i[ex_data_pkg::WORD_W-1] ^ reg2_i[ex_data_pkg::WORD_W-1]))
                   ? -prod_mag : prod_mag;

    assign mul_lo_o = product[ex_data_pkg::WORD_W-1:0];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            acc_busy <= 1'b0;
        end else begin
            acc_busy <= start_i && acc_op;
        end
    end

    // MSUB stores the negated product so both forms just add
    always_ff @(posedge clk_i) begin
        if (start_i && acc_op) begin
            acc_term <= neg_op ? -product : product;
        end
    end

    assign hilo_we_o    = (start_i && mult_op) || acc_busy;
    assign hilo_wdata_o = acc_busy ? ({hi_i, lo_i} + acc_term) : product;
    assign acc_busy_o   = acc_busy;

endmodule

// ==== rtl/ex_hilo_reg.sv ====
`timescale 1ns/1ns

module ex_hilo_reg (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            mthi_i,
    input  logic                            mtlo_i,
    input  logic [ex_data_pkg::WORD_W-1:0]  move_data_i,
    input  logic                            mul_we_i,
    input  logic [ex_data_pkg::DWORD_W-1:0] mul_data_i,
    output logic [ex_data_pkg::WORD_W-1:0]  hi_o,
    output logic [ex_data_pkg::WORD_W-1:0]  lo_o
);

    logic [ex_data_pkg::WORD_W-1:0] hi_q;
    logic [ex_data_pkg::WORD_W-1:0] lo_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (mul_we_i) begin
            // full pair write wins over a move
            {hi_q, lo_q} <= mul_data_i;
        end else begin
            if (mthi_i) begin
                hi_q <= move_data_i;
            end
            if (mtlo_i) begin
                lo_q <= move_data_i;
            end
        end
    end

    assign hi_o = hi_q;
    assign lo_o = lo_q;

endmodule

// ==== rtl/ex_stage.sv ====
`timescale 1ns/1ns

module ex_stage (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               in_valid_i,
    input  ex_isa_pkg::aluop_e                 aluop_i,
    input  logic [ex_data_pkg::WORD_W-1:0]     reg1_i,
    input  logic [ex_data_pkg::WORD_W-1:0]     reg2_i,
    input  logic [ex_data_pkg::REG_ADDR_W-1:0] wd_i,
    input  logic                               wreg_i,
    input  logic                               out_ready_i,
    output logic                               in_ready_o,
    output logic                               out_valid_o,
    output logic [ex_data_pkg::REG_ADDR_W-1:0] wd_o,
    output logic                               wreg_o,
    output logic [ex_data_pkg::WORD_W-1:0]     wdata_o,
    output logic                               ov_o,
    output logic                               trap_o
);

    ex_isa_pkg::aluop_e                 hold_op;
    logic [ex_data_pkg::REG_ADDR_W-1:0] hold_wd;
    logic                               hold_wreg;
    ex_isa_pkg::aluop_e                 cur_op;
    logic [ex_data_pkg::REG_ADDR_W-1:0] cur_wd;
    logic                               cur_wreg;
    ex_isa_pkg::alusel_e                sel;
    logic                               accept;
    logic                               acc_busy;
    logic                               is_acc;
    logic                               load;
    logic [ex_data_pkg::WORD_W-1:0]     ls_res;
    logic [ex_data_pkg::WORD_W-1:0]     arith_res;
    logic                               arith_ov;
    logic                               arith_trap;
    logic [ex_data_pkg::WORD_W-1:0]     mul_lo;
    logic                               hilo_we;
    logic [ex_data_pkg::DWORD_W-1:0]    hilo_wdata;
    logic [ex_data_pkg::WORD_W-1:0]     hi;
    logic [ex_data_pkg::WORD_W-1:0]     lo;
    logic [ex_data_pkg::WORD_W-1:0]     sel_data;

    // no new work while accumulating or while the output is stuck
    assign in_ready_o = !acc_busy && (!out_valid_o || out_ready_i);
    assign accept     = in_valid_i && in_ready_o;

    assign cur_op   = acc_busy ? hold_op   : aluop_i;
    assign cur_wd   = acc_busy ? hold_wd   : wd_i;
    assign cur_wreg = acc_busy ? hold_wreg : wreg_i;

    assign is_acc = cur_op inside {ex_isa_pkg::OP_MADD, ex_isa_pkg::OP_MADDU,
                                   ex_isa_pkg::OP_MSUB, ex_isa_pkg::OP_MSUBU};

    // accumulates retire one cycle after acceptance
    assign load = (accept && !is_acc) || acc_busy;

    always_ff @(posedge clk_i) begin
        if (accept) begin
            hold_op   <= aluop_i;
            hold_wd   <= wd_i;
            hold_wreg <= wreg_i;
        end
    end

    ex_logic_shift u_logic_shift (
        .aluop_i  (cur_op),
        .reg1_i   (reg1_i),
        .reg2_i   (reg2_i),
        .result_o (ls_res)
    );

    ex_alu_arith u_alu_arith (
        .aluop_i  (cur_op),
        .reg1_i   (reg1_i),
        .reg2_i   (reg2_i),
        .result_o (arith_res),
        .ov_o     (arith_ov),
        .trap_o   (arith_trap)
    );

    ex_mul_acc u_mul_acc (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .start_i      (accept),
        .aluop_i      (cur_op),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .hi_i         (hi),
        .lo_i         (lo),
        .mul_lo_o     (mul_lo),
        .hilo_we_o    (hilo_we),
        .hilo_wdata_o (hilo_wdata),
        .acc_busy_o   (acc_busy)
    );

    ex_hilo_reg u_hilo_reg (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .mthi_i      (accept && (cur_op == ex_isa_pkg::OP_MTHI)),
        .mtlo_i      (accept && (cur_op == ex_isa_pkg::OP_MTLO)),
        .move_data_i (reg1_i),
        .mul_we_i    (hilo_we),
        .mul_data_i  (hilo_wdata),
        .hi_o        (hi),
        .lo_o        (lo)
    );

    assign sel = ex_isa_pkg::alusel_of(cur_op);

    always_comb begin
        case (sel)
            ex_isa_pkg::SEL_LOGIC, ex_isa_pkg::SEL_SHIFT: sel_data = ls_res;
            ex_isa_pkg::SEL_ARITH: sel_data = arith_res;
            ex_isa_pkg::SEL_MOVE:  sel_data = (cur_op == ex_isa_pkg::OP_MFHI) ? hi : lo;
            ex_isa_pkg::SEL_MUL:   sel_data = mul_lo;
            default:               sel_data = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
            wreg_o      <= 1'b0;
            ov_o        <= 1'b0;
            trap_o      <= 1'b0;
        end else if (load) begin
            out_valid_o <= 1'b1;
            // overflow cancels the register write
            wreg_o      <= cur_wreg && !arith_ov;
            ov_o        <= arith_ov;
            trap_o      <= arith_trap;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            wd_o    <= cur_wd;
            wdata_o <= sel_data;
        end
    end

endmodule

// ==== dv/tb_ex_stage.sv ====
`timescale 1ns/1ns

module tb_ex_stage;

    typedef struct packed {
        logic [ex_data_pkg::REG_ADDR_W-1:0] wd;
        logic                               wreg;
        logic [ex_data_pkg::WORD_W-1:0]     wdata;
        logic                               ov;
        logic                               trap;
        logic [ex_data_pkg::WORD_W-1:0]     hi;
        logic [ex_data_pkg::WORD_W-1:0]     lo;
    } exp_t;

    logic                               clk_i = 1'b0;
    logic                               rst_n_i;
    logic                               in_valid_i;
    ex_isa_pkg::aluop_e                 aluop_i;
    logic [ex_data_pkg::WORD_W-1:0]     reg1_i;
    logic [ex_data_pkg::WORD_W-1:0]     reg2_i;
    logic [ex_data_pkg::REG_ADDR_W-1:0] wd_i;
    logic                               wreg_i;
    logic                               out_ready_i;
    logic                               in_ready_o;
    logic                               out_valid_o;
    logic [ex_data_pkg::REG_ADDR_W-1:0] wd_o;
    logic                               wreg_o;
    logic [ex_data_pkg::WORD_W-1:0]     wdata_o;
    logic                               ov_o;
    logic                               trap_o;

    int          check_cnt = 0;
    int          mismatch_cnt = 0;
    int          other_cnt = 0;
    bit          stall_mode;
    logic [31:0] stim_state;
    logic [31:0] bp_state;
    logic [31:0] model_hi;
    logic [31:0] model_lo;
    exp_t        exp_q[$];
    exp_t        head;

    // grouped by kind, index ranges are used by the random runs
    ex_isa_pkg::aluop_e op_list [0:33] = '{
        ex_isa_pkg::OP_AND, ex_isa_pkg::OP_OR, ex_isa_pkg::OP_XOR, ex_isa_pkg::OP_NOR,
        ex_isa_pkg::OP_SLL, ex_isa_pkg::OP_SRL, ex_isa_pkg::OP_SRA,
        ex_isa_pkg::OP_ADD, ex_isa_pkg::OP_ADDU, ex_isa_pkg::OP_ADDI, ex_isa_pkg::OP_ADDIU,
        ex_isa_pkg::OP_SUB, ex_isa_pkg::OP_SUBU, ex_isa_pkg::OP_SLT, ex_isa_pkg::OP_SLTU,
        ex_isa_pkg::OP_CLZ, ex_isa_pkg::OP_CLO,
        ex_isa_pkg::OP_TEQ, ex_isa_pkg::OP_TNE, ex_isa_pkg::OP_TGE, ex_isa_pkg::OP_TGEU,
        ex_isa_pkg::OP_TLT, ex_isa_pkg::OP_TLTU,
        ex_isa_pkg::OP_MUL, ex_isa_pkg::OP_MULT, ex_isa_pkg::OP_MULTU,
        ex_isa_pkg::OP_MADD, ex_isa_pkg::OP_MADDU, ex_isa_pkg::OP_MSUB, ex_isa_pkg::OP_MSUBU,
        ex_isa_pkg::OP_MFHI, ex_isa_pkg::OP_MFLO, ex_isa_pkg::OP_MTHI, ex_isa_pkg::OP_MTLO
    };

    ex_stage u_dut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .aluop_i     (aluop_i),
        .reg1_i      (reg1_i),
        .reg2_i      (reg2_i),
        .wd_i        (wd_i),
        .wreg_i      (wreg_i),
        .out_ready_i (out_ready_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .wd_o        (wd_o),
        .wreg_o      (wreg_o),
        .wdata_o     (wdata_o),
        .ov_o        (ov_o),
        .trap_o      (trap_o)
    );

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_word();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    // corner words show up often
    function automatic logic [31:0] pick_operand();
        logic [31:0] w;
        w = next_word();
        case (w[3:0])
            4'd0: return 32'h0000_0000;
            4'd1: return 32'hffff_ffff;
            4'd2: return 32'h8000_0000;
            4'd3: return 32'h7fff_ffff;
            4'd4: return next_word() >> w[8:4];
            default: return next_word();
        endcase
    endfunction

    function automatic exp_t ref_result(input ex_isa_pkg::aluop_e op,
                                        input logic [31:0] a, input logic [31:0] b,
                                        input logic [4:0] wd, input logic wreg,
                                        input logic [31:0] hi, input logic [31:0] lo);
        exp_t        e;
        logic [32:0] ext;
        logic [63:0] sprod;
        logic [63:0] uprod;
        int          n;
        e     = '0;
        e.wd  = wd;
        e.hi  = hi;
        e.lo  = lo;
        n     = 0;
        // low 64 bits of the sign extended product equal the signed product
        sprod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        uprod = {32'b0, a} * {32'b0, b};
        case (op)
            ex_isa_pkg::OP_AND:   e.wdata = a & b;
            ex_isa_pkg::OP_OR:    e.wdata = a | b;
            ex_isa_pkg::OP_XOR:   e.wdata = a ^ b;
            ex_isa_pkg::OP_NOR:   e.wdata = ~(a | b);
            ex_isa_pkg::OP_SLL:   e.wdata = b << a[4:0];
            ex_isa_pkg::OP_SRL:   e.wdata = b >> a[4:0];
            ex_isa_pkg::OP_SRA:   e.wdata = $signed(b) >>> a[4:0];
            ex_isa_pkg::OP_ADD, ex_isa_pkg::OP_ADDI: begin
                ext     = {a[31], a} + {b[31], b};
                e.wdata = ext[31:0];
                e.ov    = ext[32] ^ ext[31];
            end
            ex_isa_pkg::OP_SUB: begin
                ext     = {a[31], a} - {b[31], b};
                e.wdata = ext[31:0];
                e.ov    = ext[32] ^ ext[31];
            end
            ex_isa_pkg::OP_ADDU, ex_isa_pkg::OP_ADDIU: e.wdata = a + b;
            ex_isa_pkg::OP_SUBU:  e.wdata = a - b;
            ex_isa_pkg::OP_SLT:   e.wdata = {31'b0, $signed(a) < $signed(b)};
            ex_isa_pkg::OP_SLTU:  e.wdata = {31'b0, a < b};
            ex_isa_pkg::OP_CLZ: begin
                while (n < 32 && !a[31-n]) n++;
                e.wdata = 32'(n);
            end
            ex_isa_pkg::OP_CLO: begin
                while (n < 32 && a[31-n]) n++;
                e.wdata = 32'(n);
            end
            ex_isa_pkg::OP_TEQ:   e.trap = (a == b);
            ex_isa_pkg::OP_TNE:   e.trap = (a != b);
            ex_isa_pkg::OP_TGE:   e.trap = ($signed(a) >= $signed(b));
            ex_isa_pkg::OP_TLT:   e.trap = ($signed(a) < $signed(b));
            ex_isa_pkg::OP_TGEU:  e.trap = (a >= b);
            ex_isa_pkg::OP_TLTU:  e.trap = (a < b);
            ex_isa_pkg::OP_MUL:   e.wdata = sprod[31:0];
            ex_isa_pkg::OP_MULT:  {e.hi, e.lo} = sprod;
            ex_isa_pkg::OP_MULTU: {e.hi, e.lo} = uprod;
            ex_isa_pkg::OP_MADD:  {e.hi, e.lo} = {hi, lo} + sprod;
            ex_isa_pkg::OP_MADDU: {e.hi, e.lo} = {hi, lo} + uprod;
            ex_isa_pkg::OP_MSUB:  {e.hi, e.lo} = {hi, lo} - sprod;
            ex_isa_pkg::OP_MSUBU: {e.hi, e.lo} = {hi, lo} - uprod;
            ex_isa_pkg::OP_MFHI:  e.wdata = hi;
            ex_isa_pkg::OP_MFLO:  e.wdata = lo;
            ex_isa_pkg::OP_MTHI:  e.hi = a;
            ex_isa_pkg::OP_MTLO:  e.lo = a;
            default: ;
        endcase
        e.wreg = wreg && !e.ov;
        return e;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] want);
        check_cnt++;
        if (got !== want) begin
            mismatch_cnt++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    task automatic end_run(input bit timed_out);
        $display("checks %0d, value mismatches %0d, other errors %0d",
                 check_cnt, mismatch_cnt, other_cnt);
        if (!timed_out && mismatch_cnt == 0 && other_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // called 1 ns after a rising edge, returns at the same point after acceptance
    task automatic issue(input ex_isa_pkg::aluop_e op, input logic [31:0] a,
                         input logic [31:0] b);
        exp_t        e;
        logic [31:0] w;
        int          waited;
        w          = next_word();
        in_valid_i = 1'b1;
        aluop_i    = op;
        reg1_i     = a;
        reg2_i     = b;
        wd_i       = w[4:0];
        wreg_i     = w[5] | w[6];
        waited     = 0;
        @(negedge clk_i);
        while (!in_ready_o) begin
            waited++;
            if (waited >= 100) begin
                other_cnt++;
                $display("timeout: in_ready_o stayed low for 100 cycles at %0t", $time);
                end_run(1'b1);
            end
            @(negedge clk_i);
        end
        e        = ref_result(op, a, b, wd_i, wreg_i, model_hi, model_lo);
        model_hi = e.hi;
        model_lo = e.lo;
        exp_q.push_back(e);
        @(posedge clk_i);
        #1;
        in_valid_i = 1'b0;
        // accumulate blocks the input for exactly one cycle
        if (!stall_mode && op inside {ex_isa_pkg::OP_MADD, ex_isa_pkg::OP_MADDU,
                                      ex_isa_pkg::OP_MSUB, ex_isa_pkg::OP_MSUBU}) begin
            @(negedge clk_i);
            check_val("in_ready_o", in_ready_o, 0);
            @(negedge clk_i);
            check_val("in_ready_o", in_ready_o, 1);
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic run_random(input int first, input int count, input int num);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        int          idx;
        for (int k = 0; k < num; k++) begin
            w   = next_word();
            idx = first + int'(w[15:0]) % count;
            a   = pick_operand();
            b   = pick_operand();
            issue(op_list[idx], a, b);
        end
    endtask

    // sink side back-pressure
    always @(posedge clk_i) begin
        #1;
        if (stall_mode) begin
            bp_state    = xorshift32(bp_state);
            out_ready_i = bp_state[2:0] > 3'd2;
        end else begin
            out_ready_i = 1'b1;
        end
    end

    always @(negedge clk_i) begin
        if (rst_n_i && out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
                other_cnt++;
                $display("result 0x%0h came out with no instruction pending at %0t",
                         wdata_o, $time);
            end else begin
                head = exp_q.pop_front();
                check_val("wd_o", wd_o, head.wd);
                check_val("wreg_o", wreg_o, head.wreg);
                check_val("wdata_o", wdata_o, head.wdata);
                check_val("ov_o", ov_o, head.ov);
                check_val("trap_o", trap_o, head.trap);
            end
        end
    end

    initial begin
        int waited;
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        aluop_i     = ex_isa_pkg::OP_NOP;
        reg1_i      = '0;
        reg2_i      = '0;
        wd_i        = '0;
        wreg_i      = 1'b0;
        out_ready_i = 1'b1;
        stall_mode  = 1'b0;
        stim_state  = 32'd83481;
        bp_state    = ~32'd83481;
        model_hi    = '0;
        model_lo    = '0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_val("out_valid_o", out_valid_o, 0);
        check_val("in_ready_o", in_ready_o, 1);
        check_val("wreg_o", wreg_o, 0);
        check_val("ov_o", ov_o, 0);
        check_val("trap_o", trap_o, 0);
        @(posedge clk_i);
        #1;
        issue(ex_isa_pkg::OP_MFHI, 32'h0, 32'h0);
        issue(ex_isa_pkg::OP_MFLO, 32'h0, 32'h0);

        // logic and shifts, shift amounts wrap
        issue(ex_isa_pkg::OP_SRA, 32'h0000_0024, 32'h8765_4321);
        issue(ex_isa_pkg::OP_SRL, 32'hffff_ffe1, 32'h8000_0000);
        issue(ex_isa_pkg::OP_SLL, 32'h0000_003f, 32'h0000_0003);
        run_random(0, 7, 40);

        // overflow corners
        issue(ex_isa_pkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
        issue(ex_isa_pkg::OP_ADDI, 32'h8000_0000, 32'hffff_ffff);
        issue(ex_isa_pkg::OP_SUB, 32'h8000_0000, 32'h0000_0001);
        issue(ex_isa_pkg::OP_SUB, 32'h7fff_ffff, 32'hffff_ffff);
        issue(ex_isa_pkg::OP_ADDU, 32'h7fff_ffff, 32'h0000_0001);
        issue(ex_isa_pkg::OP_SUBU, 32'h8000_0000, 32'h0000_0001);
        issue(ex_isa_pkg::OP_CLZ, 32'h0000_0000, 32'h0);
        issue(ex_isa_pkg::OP_CLZ, 32'hffff_ffff, 32'h0);
        issue(ex_isa_pkg::OP_CLO, 32'hffff_ffff, 32'h0);
        issue(ex_isa_pkg::OP_CLO, 32'h0000_0000, 32'h0);
        issue(ex_isa_pkg::OP_CLZ, 32'h0001_0000, 32'h0);
        run_random(7, 10, 60);

        for (int i = 17; i < 23; i++) begin
            issue(op_list[i], 32'h8000_0000, 32'h7fff_ffff);
            issue(op_list[i], 32'h7fff_ffff, 32'h8000_0000);
            issue(op_list[i], 32'h0000_0000, 32'hffff_ffff);
            issue(op_list[i], 32'h8000_0000, 32'h8000_0000);
        end
        run_random(17, 6, 30);

        issue(ex_isa_pkg::OP_MULT, 32'h8000_0000, 32'h7fff_ffff);
        issue(ex_isa_pkg::OP_MFHI, 32'h0, 32'h0);
        issue(ex_isa_pkg::OP_MFLO, 32'h0, 32'h0);
        issue(ex_isa_pkg::OP_MULTU, 32'hffff_ffff, 32'hffff_ffff);
        issue(ex_isa_pkg::OP_MFHI, 32'h0, 32'h0);
        issue(ex_isa_pkg::OP_MFLO, 32'h0, 32'h0);
        issue(ex_isa_pkg::OP_MTHI, 32'hdead_0001, 32'h0);
        issue(ex_isa_pkg::OP_MTLO, 32'h0bad_f00d, 32'h0);
        issue(ex_isa_pkg::OP_MFHI, 32'h0, 32'h0);
        issue(ex_isa_pkg::OP_MFLO, 32'h0, 32'h0);
        run_random(23, 3, 20);

        // accumulate chains, read back after each step
        for (int i = 0; i < 12; i++) begin
            run_random(26, 4, 1);
            issue(ex_isa_pkg::OP_MFHI, 32'h0, 32'h0);
            issue(ex_isa_pkg::OP_MFLO, 32'h0, 32'h0);
        end

        stall_mode = 1'b1;
        run_random(0, 34, 300);
        stall_mode = 1'b0;

        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            waited++;
            if (waited >= 100) begin
                other_cnt++;
                $display("timeout: %0d results still pending after 100 cycles", exp_q.size());
                end_run(1'b1);
            end
        end
        end_run(1'b0);
    end

endmodule

// ==== tb.f ====
rtl/ex_data_pkg.sv
rtl/ex_isa_pkg.sv
rtl/ex_logic_shift.sv
rtl/ex_alu_arith.sv
rtl/ex_mul_acc.sv
rtl/ex_hilo_reg.sv
rtl/ex_stage.sv
dv/tb_ex_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -E '\.s?v$$' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BUILD_DIR)/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qxF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
